//--- rtl/lamp_pkg.sv
// lamp_pkg: shared widths, settings frame layout, PWM prescale
// and the built-in RGBW palette for the lamp controller
package lamp_pkg;

    // one channel level
    typedef logic [7:0] duty_t;

    // four channel levels, index 0 is red, then green, blue, white
    typedef duty_t [0:3] rgbw_t;

    // multiplier operand width
    localparam int MULT_W = 8;

    // settings frame, one byte per field, sent in this order
    localparam int FRAME_BYTES = 7;
    localparam int BYTE_MODE   = 0;
    localparam int BYTE_LINT   = 1;
    localparam int BYTE_IDX    = 2;
    localparam int BYTE_RED    = 3;
    localparam int BYTE_GREEN  = 4;
    localparam int BYTE_BLUE   = 5;
    localparam int BYTE_WHITE  = 6;

    // bit position in the mode byte, 1 = palette, 0 = direct
    localparam int MODE_PALETTE = 0;

    // clk cycles per pwm counter step
    localparam int PWM_PRESC = 4;
    localparam int PRESC_W   = $clog2(PWM_PRESC);

    // palette, indexed by color_idx[2:0]
    localparam rgbw_t [0:7] PALETTE = '{
        '{8'h00, 8'h00, 8'h00, 8'h00},  // off
        '{8'hff, 8'h00, 8'h00, 8'h00},  // red
        '{8'h00, 8'hff, 8'h00, 8'h00},  // green
        '{8'h00, 8'h00, 8'hff, 8'h00},  // blue
        '{8'h00, 8'h00, 8'h00, 8'hff},  // white led only
        '{8'hff, 8'h80, 8'h20, 8'h40},  // warm
        '{8'h00, 8'hff, 8'hff, 8'h00},  // cyan
        '{8'hff, 8'hff, 8'hff, 8'hff}   // everything on
    };

endpackage

//--- rtl/lamp_ifs.sv
// lamp interfaces: settings bus, multiplier port and duty bus
// shared by the blocks inside the lamp top level
`timescale 1ns/100ps

// decoded settings frame plus commit strobe
interface settings_if;
    logic [7:0]      mode;
    logic [7:0]      lint;
    logic [7:0]      color_idx;
    lamp_pkg::duty_t red;
    lamp_pkg::duty_t green;
    lamp_pkg::duty_t blue;
    lamp_pkg::duty_t white;
    logic            update;

    modport src (output mode, lint, color_idx, red, green, blue, white, update);
    modport dst (input  mode, lint, color_idx, red, green, blue, white, update);
endinterface

// load / ready port of the shared multiplier
interface mult_if;
    logic                          ld;
    logic [lamp_pkg::MULT_W-1:0]   a;
    logic [lamp_pkg::MULT_W-1:0]   b;
    logic [2*lamp_pkg::MULT_W-1:0] result;
    logic                          rdy;

    modport host (output ld, a, b, input result, rdy);
    modport unit (input ld, a, b, output result, rdy);
endinterface

// per channel levels, all four move together
interface duty_if;
    lamp_pkg::duty_t red;
    lamp_pkg::duty_t green;
    lamp_pkg::duty_t blue;
    lamp_pkg::duty_t white;

    modport src (output red, green, blue, white);
    modport dst (input  red, green, blue, white);
endinterface

//--- rtl/spi_slave.sv
// spi_slave: mode-0 receiver, msb first, oversampled on clk
// strobes each complete byte received while cs is low
`timescale 1ns/100ps

module spi_slave (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sck,
    input  logic       cs,
    input  logic       mosi,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_active
);

    // two flop synchronizers, bit 1 is the safe one
    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;
    logic       sck_rise;
    logic [2:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck_sync  <= 2'b00;
            cs_sync   <= 2'b11;   // idle = deselected
            mosi_sync <= 2'b00;
            sck_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], sck};
            cs_sync   <= {cs_sync[0], cs};
            mosi_sync <= {mosi_sync[0], mosi};
            sck_prev  <= sck_sync[1];
        end
    end

    // rising edge of the synchronized clock
    assign sck_rise     = sck_sync[1] & ~sck_prev;
    assign frame_active = ~cs_sync[1];

    // bit counter, cleared between frames
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!frame_active) begin
                bit_cnt <= 3'd0;
            end else if (sck_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;
                // eighth bit lands this edge
                rx_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    // shift register, msb enters first
    always_ff @(posedge clk) begin
        if (frame_active && sck_rise) begin
            rx_byte <= {rx_byte[6:0], mosi_sync[1]};
        end
    end

endmodule

//--- rtl/frame_deserializer.sv
// frame_deserializer: stages the bytes of one cs frame by position
// and commits all seven settings fields at once when the frame completes
`timescale 1ns/100ps

module frame_deserializer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    input  logic       frame_active,
    settings_if.src    settings
);

    // index saturates at FRAME_BYTES, extra bytes fall on the floor
    logic [$clog2(lamp_pkg::FRAME_BYTES+1)-1:0] byte_idx;
    logic [7:0] stage [lamp_pkg::FRAME_BYTES];
    logic       commit;
    logic       take;

    // byte still belongs to the frame
    assign take = rx_valid && frame_active && (byte_idx < lamp_pkg::FRAME_BYTES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_idx        <= '0;
            commit          <= 1'b0;
            settings.update <= 1'b0;
        end else begin
            commit          <= 1'b0;
            settings.update <= commit;
            if (!frame_active) begin
                // short frame just gets dropped here
                byte_idx <= '0;
            end else if (take) begin
                byte_idx <= byte_idx + 1'b1;
                commit   <= (byte_idx == lamp_pkg::FRAME_BYTES - 1);
            end
        end
    end

    // staging by byte position
    always_ff @(posedge clk) begin
        if (take) begin
            stage[byte_idx] <= rx_byte;
        end
    end

    // fields move only together with update
    always_ff @(posedge clk) begin
        if (commit) begin
            settings.mode      <= stage[lamp_pkg::BYTE_MODE];
            settings.lint      <= stage[lamp_pkg::BYTE_LINT];
            settings.color_idx <= stage[lamp_pkg::BYTE_IDX];
            settings.red       <= stage[lamp_pkg::BYTE_RED];
            settings.green     <= stage[lamp_pkg::BYTE_GREEN];
            settings.blue      <= stage[lamp_pkg::BYTE_BLUE];
            settings.white     <= stage[lamp_pkg::BYTE_WHITE];
        end
    end

endmodule

//--- rtl/mult8x8.sv
// mult8x8: unsigned shift-add multiplier, one multiplier bit per cycle
// rdy pulses 9 cycles after ld, result holds until the next ld
`timescale 1ns/100ps

module mult8x8 (
    input  logic clk,
    input  logic rst_n,
    mult_if.unit mul
);

    logic                                  busy;
    logic [$clog2(lamp_pkg::MULT_W)-1:0]   bit_cnt;
    // multiplicand, shifted left each step
    logic [2*lamp_pkg::MULT_W-1:0]         mcand;
    // multiplier, lsb is the bit under work
    logic [lamp_pkg::MULT_W-1:0]           mplier;

    // control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            mul.rdy <= 1'b0;
        end else begin
            mul.rdy <= 1'b0;
            if (mul.ld) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                // last partial product goes in now
                if (bit_cnt == lamp_pkg::MULT_W - 1) begin
                    busy    <= 1'b0;
                    mul.rdy <= 1'b1;
                end
            end
        end
    end

    // datapath, accumulator doubles as the result
    always_ff @(posedge clk) begin
        if (mul.ld) begin
            mcand      <= {{lamp_pkg::MULT_W{1'b0}}, mul.a};
            mplier     <= mul.b;
            mul.result <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                mul.result <= mul.result + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

//--- rtl/color_gen.sv
// color_gen: picks the base color (direct or palette) and scales each
// channel by intensity on the shared multiplier, duties update as a set
`timescale 1ns/100ps

module color_gen (
    input  logic    clk,
    input  logic    rst_n,
    settings_if.dst settings,
    mult_if.host    mul,
    duty_if.src     duty
);

    // base color as selected by the current settings
    lamp_pkg::rgbw_t base_sel;
    // snapshot taken at job start
    lamp_pkg::rgbw_t base_q;
    logic [7:0]      lint_q;

    logic            running;
    logic            pending;
    logic [1:0]      ch;
    logic            ld_q;
    // first three scaled channels, white goes straight to the output
    lamp_pkg::duty_t prod [3];

    // palette only looks at the low index bits
    assign base_sel = settings.mode[lamp_pkg::MODE_PALETTE]
                    ? lamp_pkg::PALETTE[settings.color_idx[2:0]]
                    : {settings.red, settings.green, settings.blue, settings.white};

    // operands come from the snapshot, stable during ld
    assign mul.ld = ld_q;
    assign mul.a  = base_q[ch];
    assign mul.b  = lint_q;

    // job sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running    <= 1'b0;
            pending    <= 1'b0;
            ch         <= 2'd0;
            ld_q       <= 1'b0;
            duty.red   <= '0;
            duty.green <= '0;
            duty.blue  <= '0;
            duty.white <= '0;
        end else begin
            ld_q <= 1'b0;
            if (!running) begin
                // idle, start on a new frame or a held one
                if (settings.update || pending) begin
                    running <= 1'b1;
                    pending <= 1'b0;
                    ch      <= 2'd0;
                    ld_q    <= 1'b1;
                end
            end else begin
                // late frame, run again once this job is done
                if (settings.update) begin
                    pending <= 1'b1;
                end
                if (mul.rdy) begin
                    if (ch == 2'd3) begin
                        running    <= 1'b0;
                        duty.red   <= prod[0];
                        duty.green <= prod[1];
                        duty.blue  <= prod[2];
                        duty.white <= mul.result[15:8];
                    end else begin
                        ch   <= ch + 2'd1;
                        ld_q <= 1'b1;
                    end
                end
            end
        end
    end

    // snapshot of the settings at job start
    always_ff @(posedge clk) begin
        if (!running && (settings.update || pending)) begin
            base_q <= base_sel;
            lint_q <= settings.lint;
        end
    end

    // keep the upper product byte, i.e. (base * lint) >> 8
    always_ff @(posedge clk) begin
        if (running && mul.rdy && ch != 2'd3) begin
            prod[ch] <= mul.result[15:8];
        end
    end

endmodule

//--- rtl/pwm_gen.sv
// pwm_gen: prescaled 8-bit counter, four registered compare outputs
// a pin is high while the counter is below its channel duty
`timescale 1ns/100ps

module pwm_gen (
    input  logic clk,
    input  logic rst_n,
    duty_if.dst  duty,
    output logic red,
    output logic green,
    output logic blue,
    output logic white
);

    logic [lamp_pkg::PRESC_W-1:0] presc;
    logic                         tick;
    lamp_pkg::duty_t              cnt;

    // clock enable for the pwm counter
    assign tick = (presc == lamp_pkg::PRESC_W'(lamp_pkg::PWM_PRESC - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc <= '0;
            cnt   <= '0;
            red   <= 1'b0;
            green <= 1'b0;
            blue  <= 1'b0;
            white <= 1'b0;
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
            // counter wraps naturally at 256
            if (tick) begin
                cnt <= cnt + 8'd1;
            end
            // duty 0 never lights, ff is on 255 of 256 steps
            red   <= (cnt < duty.red);
            green <= (cnt < duty.green);
            blue  <= (cnt < duty.blue);
            white <= (cnt < duty.white);
        end
    end

endmodule

//--- rtl/rgbw_lamp.sv
// rgbw_lamp: four-channel lamp controller top level
// spi settings frame -> color generator on the shared multiplier -> pwm
`timescale 1ns/100ps

module rgbw_lamp (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,
    input  logic cs,
    input  logic mosi,
    output logic red,
    output logic green,
    output logic blue,
    output logic white
);

    // byte strobe from the spi receiver
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       frame_active;

    settings_if settings ();
    mult_if     mul ();
    duty_if     duty ();

    // spi pins into bytes
    spi_slave u_spi (
        .clk          (clk),
        .rst_n        (rst_n),
        .sck          (sck),
        .cs           (cs),
        .mosi         (mosi),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .frame_active (frame_active)
    );

    // bytes into settings
    frame_deserializer u_deser (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .frame_active (frame_active),
        .settings     (settings.src)
    );

    // settings into duties
    color_gen u_color (
        .clk      (clk),
        .rst_n    (rst_n),
        .settings (settings.dst),
        .mul      (mul.host),
        .duty     (duty.src)
    );

    mult8x8 u_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .mul   (mul.unit)
    );

    // duties into pins
    pwm_gen u_pwm (
        .clk   (clk),
        .rst_n (rst_n),
        .duty  (duty.dst),
        .red   (red),
        .green (green),
        .blue  (blue),
        .white (white)
    );

endmodule

//--- bench/rgbw_lamp_properties.sv
// lamp assertions on the multiplier load/ready handshake and the pins in reset
`timescale 1ns/100ps

module rgbw_lamp_properties (
    input logic       clk,
    input logic       rst_n,
    input logic       ld,
    input logic       busy,
    input logic       rdy,
    input logic [3:0] pins
);

    // load only into an idle multiplier
    a_ld_idle: assert property (@(posedge clk) disable iff (!rst_n) ld |-> !busy)
        else $error("multiplier loaded while busy");

    // fixed latency of 8 bit steps plus the finish cycle
    a_rdy_latency: assert property (@(posedge clk) disable iff (!rst_n) ld |-> ##9 rdy)
        else $error("multiplier rdy not 9 cycles after ld");

    // pwm outputs come out of reset dark
    a_pins_reset: assert property (@(posedge clk) !rst_n |=> (pins == 4'b0000))
        else $error("lamp pin high right after reset");

endmodule

// one instance sees both the multiplier handshake and the pins
bind rgbw_lamp rgbw_lamp_properties u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .ld    (mul.ld),
    .busy  (u_mult.busy),
    .rdy   (mul.rdy),
    .pins  ({red, green, blue, white})
);

//--- bench/tb_rgbw_lamp.sv
// testbench for the rgbw lamp controller
// sends settings frames over spi and measures the pwm duty of each pin
`timescale 1ns/100ps

module tb_rgbw_lamp;

    localparam int SCK_HOLD    = 4;
    localparam int SETTLE_CLKS = 100;
    // one full pwm period
    localparam int WINDOW      = 256 * lamp_pkg::PWM_PRESC;

    logic clk;
    logic rst_n;
    logic sck;
    logic cs;
    logic mosi;
    logic red;
    logic green;
    logic blue;
    logic white;

    // bytes of the next frame, room for overlong frames
    logic [7:0]      frame_buf [16];
    lamp_pkg::duty_t exp_duty [4];
    lamp_pkg::duty_t got_duty [4];
    string           ch_name [4] = '{"red", "green", "blue", "white"};
    logic [31:0]     lfsr;
    int              errors;
    int              checks;
    int              tests;
    int              test_err0;

    rgbw_lamp u_dut (
        .clk(clk), .rst_n(rst_n), .sck(sck), .cs(cs), .mosi(mosi),
        .red(red), .green(green), .blue(blue), .white(white)
    );

    always #50 clk = ~clk;

    // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_byte(output logic [7:0] v);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    // built-in colors, red green blue white from msb down
    function automatic lamp_pkg::duty_t palette_level(input logic [2:0] idx, input int ch);
        logic [31:0] entry;
        case (idx)
            3'd0:    entry = 32'h00000000;
            3'd1:    entry = 32'hff000000;
            3'd2:    entry = 32'h00ff0000;
            3'd3:    entry = 32'h0000ff00;
            3'd4:    entry = 32'h000000ff;
            3'd5:    entry = 32'hff802040;
            3'd6:    entry = 32'h00ffff00;
            default: entry = 32'hffffffff;
        endcase
        return entry[31 - 8*ch -: 8];
    endfunction

    // (base * lint) >> 8 for the frame in the buffer
    function automatic lamp_pkg::duty_t expected_level(input int ch);
        logic [7:0]  base;
        logic [15:0] prod;
        if (frame_buf[lamp_pkg::BYTE_MODE][lamp_pkg::MODE_PALETTE]) begin
            base = palette_level(frame_buf[lamp_pkg::BYTE_IDX][2:0], ch);
        end else begin
            base = frame_buf[lamp_pkg::BYTE_RED + ch];
        end
        prod = base * frame_buf[lamp_pkg::BYTE_LINT];
        return prod[15:8];
    endfunction

    task automatic load_frame(input logic [7:0] mode, lint, idx, r, g, b, w);
        frame_buf[lamp_pkg::BYTE_MODE]  = mode;
        frame_buf[lamp_pkg::BYTE_LINT]  = lint;
        frame_buf[lamp_pkg::BYTE_IDX]   = idx;
        frame_buf[lamp_pkg::BYTE_RED]   = r;
        frame_buf[lamp_pkg::BYTE_GREEN] = g;
        frame_buf[lamp_pkg::BYTE_BLUE]  = b;
        frame_buf[lamp_pkg::BYTE_WHITE] = w;
    endtask

    task automatic wait_clocks(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // mode 0, data set up while sck is low, msb first
    task automatic send_frame(input int n);
        @(posedge clk);
        cs <= 1'b0;
        wait_clocks(SCK_HOLD);
        for (int i = 0; i < n; i++) begin
            for (int b = 7; b >= 0; b--) begin
                mosi <= frame_buf[i][b];
                sck  <= 1'b0;
                wait_clocks(SCK_HOLD);
                sck <= 1'b1;
                wait_clocks(SCK_HOLD);
            end
        end
        sck <= 1'b0;
        wait_clocks(SCK_HOLD);
        cs <= 1'b1;
    endtask

    // high cycles over one period, sampled away from the driving edge
    task automatic measure_duty();
        int high [4] = '{0, 0, 0, 0};
        for (int i = 0; i < WINDOW; i++) begin
            @(negedge clk);
            high[0] += red;
            high[1] += green;
            high[2] += blue;
            high[3] += white;
        end
        for (int k = 0; k < 4; k++) begin
            got_duty[k] = lamp_pkg::duty_t'(high[k] / lamp_pkg::PWM_PRESC);
        end
    endtask

    task automatic check_duty(input string name, input lamp_pkg::duty_t expected,
                              input lamp_pkg::duty_t observed);
        checks++;
        if (observed !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %02h, observed %02h",
                     $time, name, expected, observed);
        end
    endtask

    task automatic measure_and_check();
        measure_duty();
        for (int k = 0; k < 4; k++) begin
            check_duty(ch_name[k], exp_duty[k], got_duty[k]);
        end
    endtask

    // a short frame leaves the expected duties alone
    task automatic apply_frame(input int n);
        send_frame(n);
        if (n >= lamp_pkg::FRAME_BYTES) begin
            for (int ch = 0; ch < 4; ch++) begin
                exp_duty[ch] = expected_level(ch);
            end
        end
        wait_clocks(SETTLE_CLKS);
        measure_and_check();
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    initial begin
        clk = 1'b0;
        rst_n <= 1'b0;
        sck   <= 1'b0;
        cs    <= 1'b1;
        mosi  <= 1'b0;
        lfsr   = 32'hb9409d18;
        errors = 0;
        checks = 0;
        tests  = 0;
        test_err0 = 0;
        exp_duty = '{8'h00, 8'h00, 8'h00, 8'h00};
        wait_clocks(8);
        rst_n <= 1'b1;
        wait_clocks(SETTLE_CLKS);

        measure_and_check();
        finish_test("reset idle");

        // ff lint gives 00 3f 7f fe
        load_frame(8'h00, 8'hff, 8'h00, 8'h00, 8'h40, 8'h80, 8'hff);
        apply_frame(lamp_pkg::FRAME_BYTES);
        finish_test("direct full intensity");

        load_frame(8'h00, 8'h80, 8'h00, 8'h00, 8'h40, 8'h80, 8'hff);
        apply_frame(lamp_pkg::FRAME_BYTES);
        load_frame(8'h00, 8'h10, 8'h00, 8'h00, 8'h40, 8'h80, 8'hff);
        apply_frame(lamp_pkg::FRAME_BYTES);
        finish_test("intensity scaling");

        // channel bytes are junk, palette must ignore them
        for (int i = 0; i < 8; i++) begin
            load_frame(8'h01, 8'hc0, 8'(i), 8'h5a, 8'ha5, 8'h3c, 8'hc3);
            apply_frame(lamp_pkg::FRAME_BYTES);
            load_frame(8'hf1, 8'hc0, 8'(i) | 8'hf8, 8'h5a, 8'ha5, 8'h3c, 8'hc3);
            apply_frame(lamp_pkg::FRAME_BYTES);
        end
        finish_test("palette");

        load_frame(8'h00, 8'hc8, 8'h00, 8'h11, 8'h77, 8'hcc, 8'h99);
        apply_frame(lamp_pkg::FRAME_BYTES);
        load_frame(8'h00, 8'hff, 8'h00, 8'hee, 8'h22, 8'h33, 8'h44);
        apply_frame(4);
        // two trailing bytes after a full frame
        load_frame(8'h01, 8'he0, 8'h05, 8'h00, 8'h00, 8'h00, 8'h00);
        frame_buf[7] = 8'hff;
        frame_buf[8] = 8'h00;
        apply_frame(9);
        finish_test("frame length");

        for (int f = 0; f < 10; f++) begin
            for (int i = 0; i < lamp_pkg::FRAME_BYTES; i++) begin
                draw_byte(frame_buf[i]);
            end
            apply_frame(lamp_pkg::FRAME_BYTES);
        end
        finish_test("random frames");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- rgbw_lamp.f
rtl/lamp_pkg.sv
rtl/lamp_ifs.sv
rtl/spi_slave.sv
rtl/frame_deserializer.sv
rtl/mult8x8.sv
rtl/color_gen.sv
rtl/pwm_gen.sv
rtl/rgbw_lamp.sv
bench/rgbw_lamp_properties.sv
bench/tb_rgbw_lamp.sv
